// File: verilog/lenet_pkg.sv
`default_nettype none

package lenet_pkg;

	// image and layer geometry
	localparam int IMAGE_SIZE   = 12;
	localparam int IMAGE_PIXELS = IMAGE_SIZE * IMAGE_SIZE;
	localparam int KERNEL       = 5;
	localparam int KERNEL_TAPS  = KERNEL * KERNEL;
	localparam int CONV_SIZE    = IMAGE_SIZE - KERNEL + 1; // valid conv, stride 1
	localparam int POOL_SIZE    = CONV_SIZE / 2;           // 2x2 max pool
	localparam int C1_MAPS      = 2;
	localparam int FEATURES     = C1_MAPS * POOL_SIZE * POOL_SIZE;
	localparam int CLASSES      = 10;

	localparam int FRAC_BITS = 8; // q8.8 pixels and weights

	// coefficient memory regions
	localparam int CONV_W_BASE  = 0;
	localparam int CONV_B_BASE  = CONV_W_BASE + C1_MAPS * KERNEL_TAPS;
	localparam int FC_W_BASE    = CONV_B_BASE + C1_MAPS;
	localparam int FC_B_BASE    = FC_W_BASE + CLASSES * FEATURES;
	localparam int WEIGHT_DEPTH = FC_B_BASE + CLASSES;

	typedef logic signed [15:0] pixel_t;  // pixel or pooled feature
	typedef logic signed [15:0] weight_t;
	typedef logic signed [31:0] acc_t;    // wraps, no saturation
	typedef logic [7:0]         pix_addr_t;
	typedef logic [8:0]         weight_addr_t;
	typedef logic [4:0]         feat_addr_t;
	typedef logic [3:0]         digit_t;

	// top level sequencing
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_CONV,
		ST_CLASSIFY,
		ST_DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/feature_if.sv
`timescale 1ns/1ps
`default_nettype none

// pooled features, conv engine to classifier
interface feature_if import lenet_pkg::*; ();

	logic       feat_we;   // one strobe per feature
	feat_addr_t feat_addr; // map*16 + row*4 + col
	pixel_t     feat_data;
	logic       feat_last; // with the final write

	modport conv (output feat_we, feat_addr, feat_data, feat_last);
	modport fc (input feat_we, feat_addr, feat_data, feat_last);

endinterface

`default_nettype wire

// File: verilog/lenet_control.sv
`timescale 1ns/1ps
`default_nettype none

module lenet_control import lenet_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic conv_done,
	input  logic fc_done,
	output logic load_active,
	output logic conv_start,
	output logic fc_start,
	output logic result_valid
);

	ctrl_state_t state;
	pix_addr_t   load_cnt; // pixels taken so far

	logic load_last;

	assign load_last = (load_cnt == pix_addr_t'(IMAGE_PIXELS - 1));

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= ST_IDLE;
			load_cnt <= '0;
			fc_start <= 1'b0;
		end else begin
			fc_start <= conv_done && (state == ST_CONV); // one cycle behind conv_done
			case (state)
				ST_IDLE, ST_DONE: begin
					if (start) begin // only accepted here
						state    <= ST_LOAD;
						load_cnt <= '0;
					end
				end
				ST_LOAD: begin
					if (load_last)
						state <= ST_CONV;
					else
						load_cnt <= load_cnt + 1'b1;
				end
				ST_CONV: begin
					if (conv_done)
						state <= ST_CLASSIFY;
				end
				ST_CLASSIFY: begin
					if (fc_done)
						state <= ST_DONE; // digit lands on same edge
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign load_active  = (state == ST_LOAD);
	assign conv_start   = (state == ST_LOAD) && load_last; // last pixel cycle
	assign result_valid = (state == ST_DONE);

	// datapath done pulses only arrive in their own phase
	a_conv_done_phase: assert property (
		@(posedge clk) disable iff (!rst) conv_done |-> (state == ST_CONV)
	);

	a_fc_done_phase: assert property (
		@(posedge clk) disable iff (!rst) fc_done |-> (state == ST_CLASSIFY)
	);

endmodule

`default_nettype wire

// File: verilog/image_mem.sv
`timescale 1ns/1ps
`default_nettype none

module image_mem import lenet_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      load_active,
	input  pixel_t    pixel,
	input  pix_addr_t rd_addr,
	output pixel_t    rd_data
);

	pixel_t    mem [IMAGE_PIXELS]; // raster order
	pix_addr_t wr_cnt;

	// write pointer follows the load window
	always_ff @(posedge clk) begin
		if (!rst)
			wr_cnt <= '0;
		else if (load_active)
			wr_cnt <= wr_cnt + 1'b1;
		else
			wr_cnt <= '0;
	end

	always_ff @(posedge clk) begin
		if (load_active)
			mem[wr_cnt] <= pixel;
		rd_data <= mem[rd_addr]; // one cycle read latency
	end

	// window from control must not outlast the buffer
	a_wr_in_range: assert property (
		@(posedge clk) disable iff (!rst) load_active |-> (wr_cnt < IMAGE_PIXELS)
	);

endmodule

`default_nettype wire

// File: verilog/weight_mem.sv
`timescale 1ns/1ps
`default_nettype none

module weight_mem import lenet_pkg::*; (
	input  logic         clk,
	input  logic         weight_we,
	input  weight_addr_t weight_addr,
	input  weight_t      weight_data,
	input  weight_addr_t conv_addr,
	output weight_t      conv_data,
	input  weight_addr_t fc_addr,
	output weight_t      fc_data
);

	// conv weights, conv biases, fc weights, fc biases
	weight_t mem [WEIGHT_DEPTH];

	// host write port, only used while idle
	always_ff @(posedge clk) begin
		if (weight_we)
			mem[weight_addr] <= weight_data;
	end

	// conv engine port
	always_ff @(posedge clk) begin
		conv_data <= mem[conv_addr];
	end

	// classifier port
	always_ff @(posedge clk) begin
		fc_data <= mem[fc_addr];
	end

	// host must stay inside the coefficient map
	a_wr_addr_range: assert property (
		@(posedge clk) weight_we |-> (weight_addr < WEIGHT_DEPTH)
	);

endmodule

`default_nettype wire

// File: verilog/conv_pool_engine.sv
`timescale 1ns/1ps
`default_nettype none

module conv_pool_engine import lenet_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         conv_start,
	output pix_addr_t    pix_addr,
	input  pixel_t       pix_data,
	output weight_addr_t coef_addr,
	input  weight_t      coef_data,
	output logic         conv_done,
	feature_if.conv      feat
);

	// taps, then bias fetch, then activate and pool
	typedef enum logic [1:0] {
		E_IDLE,
		E_TAP,
		E_BIAS,
		E_ACT
	} eng_state_t;

	eng_state_t state;

	logic [$clog2(C1_MAPS)-1:0]   map;
	logic [$clog2(POOL_SIZE)-1:0] pr;      // pooled row
	logic [$clog2(POOL_SIZE)-1:0] pc;      // pooled col
	logic [1:0]                   sub;     // {sr, sc} inside 2x2 window
	logic [$clog2(KERNEL)-1:0]    kr;
	logic [$clog2(KERNEL)-1:0]    kc;
	logic                         tap_vld; // read data of a tap is back

	acc_t      acc;
	acc_t      prod;
	acc_t      conv_sum;
	acc_t      shifted;
	pixel_t    act;
	pixel_t    pool_max;
	pixel_t    max_next;
	pix_addr_t conv_row;
	pix_addr_t conv_col;
	logic      last_sub;
	logic      last_feat;

	always_comb begin
		prod     = pix_data * coef_data; // full 32 bit product
		conv_sum = acc + (acc_t'(coef_data) <<< FRAC_BITS); // coef_data is bias here
		shifted  = conv_sum >>> FRAC_BITS;
		act      = pixel_t'(shifted); // keep low 16 bits
		if (act[$bits(pixel_t)-1])
			act = '0; // relu
		max_next  = ((sub == 2'd0) || (act > pool_max)) ? act : pool_max;
		last_sub  = (sub == 2'd3);
		last_feat = last_sub && (map == C1_MAPS - 1) &&
			(pr == POOL_SIZE - 1) && (pc == POOL_SIZE - 1);
	end

	// window origin is 2*pooled + sub position
	always_comb begin
		conv_row = pix_addr_t'({pr, 1'b0}) + pix_addr_t'(sub[1]) + pix_addr_t'(kr);
		conv_col = pix_addr_t'({pc, 1'b0}) + pix_addr_t'(sub[0]) + pix_addr_t'(kc);
		pix_addr = pix_addr_t'(conv_row * IMAGE_SIZE + conv_col);
		if (state == E_BIAS)
			coef_addr = weight_addr_t'(CONV_B_BASE + map);
		else
			coef_addr = weight_addr_t'(CONV_W_BASE + map * KERNEL_TAPS + kr * KERNEL + kc);
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state          <= E_IDLE;
			map            <= '0;
			pr             <= '0;
			pc             <= '0;
			sub            <= '0;
			kr             <= '0;
			kc             <= '0;
			tap_vld        <= 1'b0;
			feat.feat_we   <= 1'b0;
			feat.feat_last <= 1'b0;
		end else begin
			tap_vld        <= (state == E_TAP);
			feat.feat_we   <= 1'b0;
			feat.feat_last <= 1'b0;
			case (state)
				E_IDLE: begin
					if (conv_start) begin
						state <= E_TAP;
						map   <= '0;
						pr    <= '0;
						pc    <= '0;
						sub   <= '0;
						kr    <= '0;
						kc    <= '0;
					end
				end
				E_TAP: begin
					if (kc == KERNEL - 1) begin
						kc <= '0;
						if (kr == KERNEL - 1) begin
							kr    <= '0;
							state <= E_BIAS;
						end else
							kr <= kr + 1'b1;
					end else
						kc <= kc + 1'b1;
				end
				E_BIAS: state <= E_ACT; // last product accumulates now
				E_ACT: begin
					sub            <= sub + 1'b1;
					feat.feat_we   <= last_sub;
					feat.feat_last <= last_feat;
					state          <= last_feat ? E_IDLE : E_TAP;
					if (last_sub) begin
						pc <= pc + 1'b1; // wraps since sizes are powers of two
						if (pc == POOL_SIZE - 1) begin
							pr <= pr + 1'b1;
							if (pr == POOL_SIZE - 1)
								map <= map + 1'b1;
						end
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == E_IDLE) || (state == E_ACT))
			acc <= '0;
		else if (tap_vld)
			acc <= acc + prod; // wrapping accumulate
		if (state == E_ACT) begin
			pool_max <= max_next;
			if (last_sub) begin
				feat.feat_addr <= {map, pr, pc};
				feat.feat_data <= max_next;
			end
		end
	end

	assign conv_done = feat.feat_last;

	// a new run only reaches an idle engine
	a_start_when_idle: assert property (
		@(posedge clk) disable iff (!rst) conv_start |-> (state == E_IDLE)
	);

endmodule

`default_nettype wire

// File: verilog/fc_argmax.sv
`timescale 1ns/1ps
`default_nettype none

module fc_argmax import lenet_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         fc_start,
	feature_if.fc        feat,
	output weight_addr_t coef_addr,
	input  weight_t      coef_data,
	output digit_t       digit,
	output logic         fc_done
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_MAC,
		F_BIAS,
		F_CMP
	} fc_state_t;

	fc_state_t  state;
	pixel_t     feat_buf [FEATURES];
	pixel_t     feat_q;   // lines up with coef_data
	digit_t     cls;
	digit_t     best_idx;
	feat_addr_t fidx;
	logic       mac_vld;
	acc_t       acc;
	acc_t       prod;
	acc_t       score;
	acc_t       best_score;
	logic       take;
	logic       last_cls;

	always_ff @(posedge clk) begin
		if (feat.feat_we)
			feat_buf[feat.feat_addr] <= feat.feat_data;
	end

	always_comb begin
		prod     = feat_q * coef_data;
		score    = acc + (acc_t'(coef_data) <<< FRAC_BITS); // bias in q8.8 x q8.8 scale
		take     = (cls == '0) || (score > best_score); // strict, lowest index wins ties
		last_cls = (cls == CLASSES - 1);
		if (state == F_BIAS)
			coef_addr = weight_addr_t'(FC_B_BASE + cls);
		else
			coef_addr = weight_addr_t'(FC_W_BASE + cls * FEATURES + fidx);
	end

	assign fc_done = (state == F_CMP) && last_cls; // digit updates on this edge

	always_ff @(posedge clk) begin
		if (!rst) begin
			state   <= F_IDLE;
			cls     <= '0;
			fidx    <= '0;
			mac_vld <= 1'b0;
			digit   <= '0;
		end else begin
			mac_vld <= (state == F_MAC);
			case (state)
				F_IDLE: begin
					if (fc_start) begin
						state <= F_MAC;
						cls   <= '0;
						fidx  <= '0;
					end
				end
				F_MAC: begin
					fidx <= fidx + 1'b1; // wraps back to 0
					if (fidx == FEATURES - 1)
						state <= F_BIAS;
				end
				F_BIAS: state <= F_CMP;
				F_CMP: begin
					if (last_cls) begin
						digit <= take ? cls : best_idx;
						state <= F_IDLE;
					end else begin
						cls   <= cls + 1'b1;
						state <= F_MAC;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		feat_q <= feat_buf[fidx];
		if ((state == F_IDLE) || (state == F_CMP))
			acc <= '0;
		else if (mac_vld)
			acc <= acc + prod;
		if ((state == F_CMP) && take) begin
			best_score <= score;
			best_idx   <= cls;
		end
	end

	// classifier starts right after the last feature lands
	a_start_after_last: assert property (
		@(posedge clk) disable iff (!rst) feat.feat_last |=> fc_start
	);

endmodule

`default_nettype wire

// File: verilog/lenet_top.sv
`timescale 1ns/1ps
`default_nettype none

module lenet_top import lenet_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  pixel_t       pixel,
	output logic         load_active,
	input  logic         weight_we,
	input  weight_addr_t weight_addr,
	input  weight_t      weight_data,
	output digit_t       digit,
	output logic         result_valid
);

	logic         conv_start;
	logic         conv_done;
	logic         fc_start;
	logic         fc_done;
	pix_addr_t    pix_addr;
	pixel_t       pix_data;
	weight_addr_t conv_coef_addr;
	weight_t      conv_coef_data;
	weight_addr_t fc_coef_addr;
	weight_t      fc_coef_data;

	feature_if feat_bus ();

	lenet_control i_lenet_control (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.conv_done    (conv_done),
		.fc_done      (fc_done),
		.load_active  (load_active),
		.conv_start   (conv_start),
		.fc_start     (fc_start),
		.result_valid (result_valid)
	);

	image_mem i_image_mem (
		.clk         (clk),
		.rst         (rst),
		.load_active (load_active),
		.pixel       (pixel),
		.rd_addr     (pix_addr),
		.rd_data     (pix_data)
	);

	weight_mem i_weight_mem (
		.clk         (clk),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.conv_addr   (conv_coef_addr),
		.conv_data   (conv_coef_data),
		.fc_addr     (fc_coef_addr),
		.fc_data     (fc_coef_data)
	);

	conv_pool_engine i_conv_pool_engine (
		.clk        (clk),
		.rst        (rst),
		.conv_start (conv_start),
		.pix_addr   (pix_addr),
		.pix_data   (pix_data),
		.coef_addr  (conv_coef_addr),
		.coef_data  (conv_coef_data),
		.conv_done  (conv_done),
		.feat       (feat_bus.conv)
	);

	fc_argmax i_fc_argmax (
		.clk       (clk),
		.rst       (rst),
		.fc_start  (fc_start),
		.feat      (feat_bus.fc),
		.coef_addr (fc_coef_addr),
		.coef_data (fc_coef_data),
		.digit     (digit),
		.fc_done   (fc_done)
	);

endmodule

`default_nettype wire

// File: verification/lenet_model.svh
`ifndef LENET_MODEL_SVH
`define LENET_MODEL_SVH

// reference model, reads img and coef of the including testbench

// one conv output: 25 taps, bias, shift, 16 bit truncation, relu
function automatic pixel_t conv_point(input int m, input int r, input int c);
	acc_t   acc;
	pixel_t act;
	int     kr;
	int     kc;
	acc = '0;
	for (kr = 0; kr < KERNEL; kr++) begin
		for (kc = 0; kc < KERNEL; kc++) begin
			acc = acc + acc_t'(img[(r + kr) * IMAGE_SIZE + c + kc]) *
				acc_t'(coef[CONV_W_BASE + m * KERNEL_TAPS + kr * KERNEL + kc]); // wraps at 32 bits
		end
	end
	acc = acc + (acc_t'(coef[CONV_B_BASE + m]) <<< FRAC_BITS); // bias in product scale
	acc = acc >>> FRAC_BITS;
	act = acc[15:0];
	if (act < 0)
		act = '0;
	return act;
endfunction

// max over the 2x2 window, feature index map*16 + row*4 + col
function automatic pixel_t pooled_feature(input int f);
	int     m;
	int     pr;
	int     pc;
	int     sr;
	int     sc;
	pixel_t v;
	pixel_t mx;
	m  = f / (POOL_SIZE * POOL_SIZE);
	pr = (f % (POOL_SIZE * POOL_SIZE)) / POOL_SIZE;
	pc = f % POOL_SIZE;
	mx = conv_point(m, 2 * pr, 2 * pc);
	for (sr = 0; sr < 2; sr++) begin
		for (sc = 0; sc < 2; sc++) begin
			v = conv_point(m, 2 * pr + sr, 2 * pc + sc);
			if (v > mx)
				mx = v;
		end
	end
	return mx;
endfunction

// fc scores and argmax, strict compare so lowest index wins a tie
function automatic digit_t predict_digit();
	pixel_t fv [FEATURES];
	acc_t   score;
	acc_t   best;
	digit_t best_idx;
	int     f;
	int     c;
	for (f = 0; f < FEATURES; f++)
		fv[f] = pooled_feature(f);
	best     = '0;
	best_idx = '0;
	for (c = 0; c < CLASSES; c++) begin
		score = '0;
		for (f = 0; f < FEATURES; f++)
			score = score + acc_t'(fv[f]) * acc_t'(coef[FC_W_BASE + c * FEATURES + f]);
		score = score + (acc_t'(coef[FC_B_BASE + c]) <<< FRAC_BITS);
		if ((c == 0) || (score > best)) begin
			best     = score;
			best_idx = digit_t'(c);
		end
	end
	return best_idx;
endfunction

`endif

// File: verification/lenet_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lenet_tb import lenet_pkg::*; ();

	localparam int RESULT_TIMEOUT = 10000; // conv and fc need about 3800 cycles

	logic         clk;
	logic         rst;
	logic         start;
	pixel_t       pixel;
	logic         load_active;
	logic         weight_we;
	weight_addr_t weight_addr;
	weight_t      weight_data;
	digit_t       digit;
	logic         result_valid;

	pixel_t      img [IMAGE_PIXELS];  // image of the current run
	weight_t     coef [WEIGHT_DEPTH]; // mirror of the coefficient memory
	logic [31:0] lfsr_state;
	int          errors;
	int          test_errors;
	int          tests_run;
	logic        timed_out;

	`include "lenet_model.svh"

	lenet_top i_lenet_top (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.pixel        (pixel),
		.load_active  (load_active),
		.weight_we    (weight_we),
		.weight_addr  (weight_addr),
		.weight_data  (weight_data),
		.digit        (digit),
		.result_valid (result_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic pixel_t signed10();
		logic [31:0] v;
		v = lfsr_bits(10);
		return {{6{v[9]}}, v[9:0]}; // sign extend
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s did not rise within %0d cycles", what, RESULT_TIMEOUT);
		errors++;
		test_errors++;
		timed_out = 1'b1; // later tests are skipped
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %0d %s: ok", tests_run, name);
		else
			$display("test %0d %s: %0d errors", tests_run, name, test_errors);
		test_errors = 0;
	endtask

	task automatic fill_random_coefs();
		int a;
		for (a = 0; a < WEIGHT_DEPTH; a++)
			coef[a] = signed10();
	endtask

	task automatic fill_random_image();
		int i;
		for (i = 0; i < IMAGE_PIXELS; i++)
			img[i] = signed10();
	endtask

	// one word per cycle, only while the classifier is idle
	task automatic write_coefs(input int first, input int last);
		int a;
		for (a = first; a <= last; a++) begin
			@(posedge clk);
			weight_we   <= 1'b1;
			weight_addr <= weight_addr_t'(a);
			weight_data <= coef[a];
		end
		@(posedge clk);
		weight_we <= 1'b0;
	endtask

	// start pulse, then one pixel per window cycle; window checked on the way
	task automatic load_image();
		int i;
		@(posedge clk);
		start <= 1'b1;
		@(negedge clk);
		check_value("load_active", load_active, 0);
		@(posedge clk); // DUT takes start here
		start <= 1'b0;
		pixel <= img[0];
		for (i = 0; i < IMAGE_PIXELS; i++) begin
			@(negedge clk);
			check_value("load_active", load_active, 1);
			if (i == 0)
				check_value("result_valid", result_valid, 0); // dropped by the start
			@(posedge clk);
			if (i < IMAGE_PIXELS - 1)
				pixel <= img[i + 1];
		end
		@(negedge clk);
		check_value("load_active", load_active, 0); // closed after 144 cycles
	endtask

	task automatic wait_result();
		int n;
		n = 0;
		@(negedge clk);
		while (!result_valid && (n < RESULT_TIMEOUT)) begin
			@(negedge clk);
			n++;
		end
		if (!result_valid)
			report_timeout("result_valid");
	endtask

	task automatic classify_and_check();
		load_image();
		wait_result();
		if (!timed_out)
			check_value("digit", digit, predict_digit());
	endtask

	task automatic reset_values();
		@(negedge clk);
		check_value("load_active", load_active, 0);
		check_value("result_valid", result_valid, 0);
		check_value("digit", digit, 0);
		end_test("reset values");
	endtask

	task automatic load_window();
		fill_random_coefs();
		write_coefs(0, WEIGHT_DEPTH - 1);
		fill_random_image();
		classify_and_check();
		end_test("load window");
	endtask

	task automatic random_images();
		int set;
		int k;
		for (set = 0; set < 3; set++) begin
			fill_random_coefs();
			write_coefs(0, WEIGHT_DEPTH - 1);
			for (k = 0; k < 2; k++) begin
				fill_random_image();
				if (!timed_out)
					classify_and_check();
			end
		end
		end_test("random images");
	endtask

	task automatic busy_start();
		int     i;
		digit_t held;
		fill_random_image();
		load_image();
		for (i = 0; i < 20; i++)
			@(posedge clk); // well inside the conv phase
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_value("load_active", load_active, 0); // must not reopen
		end
		wait_result();
		if (!timed_out) begin
			held = predict_digit();
			check_value("digit", digit, held);
			for (i = 0; i < 200; i++) begin
				@(negedge clk);
				check_value("digit", digit, held);
				check_value("result_valid", result_valid, 1);
			end
			fill_random_image();
			classify_and_check(); // next accepted start
		end
		end_test("start while busy");
	endtask

	// negative conv weights on a non-negative image, so every feature is zero
	task automatic relu_and_ties();
		int a;
		int c;
		int offs;
		int best_c;
		fill_random_coefs();
		for (a = CONV_W_BASE; a < CONV_B_BASE; a++)
			coef[a] = ~weight_t'(lfsr_bits(9)); // ~x is -x-1, so -1 down to -512
		for (a = CONV_B_BASE; a < FC_W_BASE; a++)
			coef[a] = '0;
		offs = int'(lfsr_bits(9));
		for (c = 0; c < CLASSES; c++)
			coef[FC_B_BASE + c] = weight_t'(((c * 53 + offs) % 512) - 256); // odd step, distinct
		for (a = 0; a < IMAGE_PIXELS; a++)
			img[a] = pixel_t'(lfsr_bits(9));
		best_c = 0;
		for (c = 1; c < CLASSES; c++)
			if (coef[FC_B_BASE + c] > coef[FC_B_BASE + best_c])
				best_c = c;
		write_coefs(0, WEIGHT_DEPTH - 1);
		load_image();
		wait_result();
		if (!timed_out) begin
			check_value("digit", digit, best_c);
			coef[FC_B_BASE] = signed10();
			for (c = 1; c < CLASSES; c++)
				coef[FC_B_BASE + c] = coef[FC_B_BASE]; // all scores tie
			write_coefs(FC_B_BASE, WEIGHT_DEPTH - 1);
			load_image();
			wait_result();
			if (!timed_out)
				check_value("digit", digit, 0);
		end
		end_test("relu and ties");
	endtask

	initial begin
		rst         = 1'b0;
		start       = 1'b0;
		pixel       = '0;
		weight_we   = 1'b0;
		weight_addr = '0;
		weight_data = '0;
		lfsr_state  = 32'h8d10;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		timed_out   = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		reset_values();
		if (!timed_out)
			load_window();
		if (!timed_out)
			random_images();
		if (!timed_out)
			busy_start();
		if (!timed_out)
			relu_and_ties();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verification
verilog/lenet_pkg.sv
verilog/feature_if.sv
verilog/lenet_control.sv
verilog/image_mem.sv
verilog/weight_mem.sv
verilog/conv_pool_engine.sv
verilog/fc_argmax.sv
verilog/lenet_top.sv
verification/lenet_tb.sv

// File: Bender.yml
package:
  name: lenet

sources:
  - files:
      - verilog/lenet_pkg.sv
      - verilog/feature_if.sv
      - verilog/lenet_control.sv
      - verilog/image_mem.sv
      - verilog/weight_mem.sv
      - verilog/conv_pool_engine.sv
      - verilog/fc_argmax.sv
      - verilog/lenet_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/lenet_tb.sv
